// ==== dv/udp_ip_tx_assert.sv ====
// output protocol assertions

`timescale 1ns/1ps

module udp_ip_tx_assert (
  input logic                          clk,
  input logic                          rst,
  input logic                          m_ip_hdr_valid,
  input logic                          m_ip_hdr_ready,
  input logic [15:0]                   m_ip_length,
  input logic [15:0]                   m_ip_identification,
  input logic [31:0]                   m_ip_source_ip,
  input logic [31:0]                   m_ip_dest_ip,
  input logic                          m_is_roce_packet,
  input logic [udp_tx_pkg::data_w-1:0] m_ip_payload_axis_tdata,
  input logic [udp_tx_pkg::keep_w-1:0] m_ip_payload_axis_tkeep,
  input logic                          m_ip_payload_axis_tvalid,
  input logic                          m_ip_payload_axis_tready,
  input logic                          m_ip_payload_axis_tlast,
  input logic                          m_ip_payload_axis_tuser,
  input logic                          error_payload_early_termination
);

  // stalled stream word stays put
  assert property (@(posedge clk) disable iff (rst)
    m_ip_payload_axis_tvalid && !m_ip_payload_axis_tready |=>
      m_ip_payload_axis_tvalid && $stable({m_ip_payload_axis_tdata, m_ip_payload_axis_tkeep,
                                           m_ip_payload_axis_tlast, m_ip_payload_axis_tuser}))
    else $error("output stream word changed while stalled");

  // stalled IP header stays put
  assert property (@(posedge clk) disable iff (rst)
    m_ip_hdr_valid && !m_ip_hdr_ready |=>
      m_ip_hdr_valid && $stable({m_ip_length, m_ip_identification, m_ip_source_ip,
                                 m_ip_dest_ip, m_is_roce_packet}))
    else $error("IP header changed while stalled");

  assert property (@(posedge clk) disable iff (rst)
    error_payload_early_termination |=> !error_payload_early_termination)
    else $error("early termination error held longer than one cycle");

endmodule

bind udp_ip_tx udp_ip_tx_assert u_assert (
  .clk(clk),
  .rst(rst),
  .m_ip_hdr_valid(m_ip_hdr_valid),
  .m_ip_hdr_ready(m_ip_hdr_ready),
  .m_ip_length(m_ip_length),
  .m_ip_identification(m_ip_identification),
  .m_ip_source_ip(m_ip_source_ip),
  .m_ip_dest_ip(m_ip_dest_ip),
  .m_is_roce_packet(m_is_roce_packet),
  .m_ip_payload_axis_tdata(m_ip_payload_axis_tdata),
  .m_ip_payload_axis_tkeep(m_ip_payload_axis_tkeep),
  .m_ip_payload_axis_tvalid(m_ip_payload_axis_tvalid),
  .m_ip_payload_axis_tready(m_ip_payload_axis_tready),
  .m_ip_payload_axis_tlast(m_ip_payload_axis_tlast),
  .m_ip_payload_axis_tuser(m_ip_payload_axis_tuser),
  .error_payload_early_termination(error_payload_early_termination)
);

// ==== dv/udp_ip_tx_tb.sv ====
// UDP to IP transmit testbench

`timescale 1ns/1ps

module udp_ip_tx_tb;
  import udp_tx_pkg::*;

  localparam int n_rows = 10;
  // dest port, UDP length, input beats, early tlast, back-pressure
  localparam logic [47:0] stim_table [n_rows] = '{
    {16'd1234, 16'd64,  8'd7, 4'd0, 4'd0},
    {16'd4791, 16'd61,  8'd7, 4'd0, 4'd0},
    {16'd5000, 16'd30,  8'd5, 4'd0, 4'd0},
    {16'd4791, 16'd100, 8'd6, 4'd0, 4'd0},
    {16'd2000, 16'd45,  8'd5, 4'd1, 4'd0},
    {16'd4791, 16'd77,  8'd9, 4'd0, 4'd1},
    {16'd3000, 16'd40,  8'd8, 4'd0, 4'd1},
    {16'd4791, 16'd90,  8'd4, 4'd0, 4'd1},
    {16'd1111, 16'd9,   8'd1, 4'd0, 4'd1},
    {16'd4791, 16'd16,  8'd3, 4'd0, 4'd1}
  };

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic s_udp_hdr_valid = 1'b0;
  logic s_udp_hdr_ready;
  logic [3:0] s_ip_version = '0, s_ip_ihl = '0;
  logic [5:0] s_ip_dscp = '0;
  logic [1:0] s_ip_ecn = '0;
  logic [15:0] s_ip_identification = '0, s_ip_header_checksum = '0;
  logic [2:0] s_ip_flags = '0;
  logic [12:0] s_ip_fragment_offset = '0;
  logic [7:0] s_ip_ttl = '0, s_ip_protocol = '0;
  logic [31:0] s_ip_source_ip = '0, s_ip_dest_ip = '0;
  logic [15:0] s_udp_source_port = '0, s_udp_dest_port = '0;
  logic [15:0] s_udp_length = '0, s_udp_checksum = '0;
  logic [data_w-1:0] s_udp_payload_axis_tdata = '0;
  logic [keep_w-1:0] s_udp_payload_axis_tkeep = '0;
  logic s_udp_payload_axis_tvalid = 1'b0;
  logic s_udp_payload_axis_tlast = 1'b0;
  logic s_udp_payload_axis_tuser = 1'b0;
  logic s_udp_payload_axis_tready;
  logic m_ip_hdr_ready = 1'b1;
  logic m_ip_payload_axis_tready = 1'b1;
  logic m_ip_hdr_valid, m_is_roce_packet, busy, error_payload_early_termination;
  logic [3:0] m_ip_version, m_ip_ihl;
  logic [5:0] m_ip_dscp;
  logic [1:0] m_ip_ecn;
  logic [15:0] m_ip_length, m_ip_identification, m_ip_header_checksum;
  logic [2:0] m_ip_flags;
  logic [12:0] m_ip_fragment_offset;
  logic [7:0] m_ip_ttl, m_ip_protocol;
  logic [31:0] m_ip_source_ip, m_ip_dest_ip;
  logic [data_w-1:0] m_ip_payload_axis_tdata;
  logic [keep_w-1:0] m_ip_payload_axis_tkeep;
  logic m_ip_payload_axis_tvalid, m_ip_payload_axis_tlast, m_ip_payload_axis_tuser;

  // scoreboard state
  logic [143:0] exp_ip [$];
  logic [15:0] exp_len [$];
  bit exp_roce [$];
  logic [data_w-1:0] exp_data [$];
  logic [keep_w-1:0] exp_keep [$];
  bit exp_last [$];
  bit exp_user [$];
  bit exp_short [$];
  logic [143:0] got_ip, want_ip;
  logic [15:0] want_len;
  logic [data_w-1:0] want_data;
  logic [keep_w-1:0] want_keep;
  bit want_roce, want_last, want_user, want_short;
  int checks = 0;
  int fails = 0;
  int busy_checks = 0;
  int busy_fails = 0;
  int err_seen = 0;
  int err_base = 0;
  int beats_seen = 0;
  int frames_done = 0;
  integer seed = 32'h4dfe69f4;
  logic [31:0] bp_draw;
  bit bp_on = 1'b0;

  assign got_ip = {m_ip_version, m_ip_ihl, m_ip_dscp, m_ip_ecn, m_ip_identification,
                   m_ip_flags, m_ip_fragment_offset, m_ip_ttl, m_ip_protocol,
                   m_ip_header_checksum, m_ip_source_ip, m_ip_dest_ip};

  udp_ip_tx UUT (.*);

  always #5 clk = ~clk;

  task automatic check_value(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("error at time %0t: %s", $time, what);
      fails++;
    end
  endtask

  // busy seen from the stimulus side of a frame
  task automatic check_busy(input bit want, input int f);
    busy_checks++;
    assert (busy == want) else begin
      $display("error at time %0t: frame %0d busy %b, expected %b", $time, f, busy, want);
      busy_fails++;
    end
  endtask

  // low n bytes enabled, all eight from n = 8 up
  function automatic logic [keep_w-1:0] byte_mask(input int n);
    return n >= 8 ? 8'hff : 8'((1 << n) - 1);
  endfunction

  function automatic logic [data_w-1:0] beat_data(input int f, input int b);
    return {16'(f), 16'(b), 32'h9e3779b9 ^ 32'(f * 97 + b * 13)};
  endfunction

  task automatic send_frame(input int f);
    logic [47:0] row;
    logic [15:0] wire_len;
    int pb;
    int need;
    int beats;
    int final_bytes;
    int out_beats;
    bit short;
    bit ok;
    row = stim_table[f];
    s_ip_version = 4'd4;
    s_ip_ihl = 4'd5;
    s_ip_dscp = 6'(f);
    s_ip_ecn = 2'(f);
    s_ip_identification = 16'h1000 + 16'(f);
    s_ip_flags = 3'b010;
    s_ip_fragment_offset = 13'(f * 3);
    s_ip_ttl = 8'd64;
    s_ip_protocol = 8'd17;
    s_ip_header_checksum = 16'hbeef ^ 16'(f);
    s_ip_source_ip = 32'hc0a80001 + 32'(f);
    s_ip_dest_ip = 32'h0a000001 + 32'(f);
    s_udp_source_port = 16'hc000 + 16'(f);
    s_udp_dest_port = row[47:32];
    s_udp_length = row[31:16];
    s_udp_checksum = 16'h5a00 + 16'(f);
    beats = int'(row[15:8]);
    bp_on = row[3:0] != 4'd0;
    pb = int'(s_udp_length) - 8;
    need = (pb + 7) / 8;
    // early tlast leaves only three bytes in the final input beat
    final_bytes = row[7:4] != 4'd0 ? 3 : (beats == need ? pb - 8 * (beats - 1) : 8);
    short = 8 * (beats - 1) + final_bytes < pb;
    out_beats = beats < need ? beats : need;
    wire_len = s_udp_dest_port == roce_udp_port ? s_udp_length + icrc_bytes : s_udp_length;
    exp_ip.push_back({s_ip_version, s_ip_ihl, s_ip_dscp, s_ip_ecn, s_ip_identification,
                      s_ip_flags, s_ip_fragment_offset, s_ip_ttl, s_ip_protocol,
                      s_ip_header_checksum, s_ip_source_ip, s_ip_dest_ip});
    exp_len.push_back(s_udp_length + ip_hdr_bytes);
    exp_roce.push_back(s_udp_dest_port == roce_udp_port);
    exp_short.push_back(short);
    // UDP header word, each field in wire byte order
    exp_data.push_back({s_udp_checksum[7:0], s_udp_checksum[15:8], wire_len[7:0],
                        wire_len[15:8], s_udp_dest_port[7:0], s_udp_dest_port[15:8],
                        s_udp_source_port[7:0], s_udp_source_port[15:8]});
    exp_keep.push_back(8'hff);
    exp_last.push_back(1'b0);
    exp_user.push_back(1'b0);
    for (int b = 0; b < out_beats; b++) begin
      exp_data.push_back(beat_data(f, b));
      exp_keep.push_back((b == beats - 1 ? byte_mask(final_bytes) : 8'hff) &
                         (b == out_beats - 1 ? byte_mask(pb - 8 * b) : 8'hff));
      exp_last.push_back(b == out_beats - 1);
      exp_user.push_back(b == out_beats - 1 && short);
    end
    s_udp_hdr_valid = 1'b1;
    do begin
      ok = s_udp_hdr_ready;
      @(negedge clk);
    end while (!ok);
    s_udp_hdr_valid = 1'b0;
    for (int b = 0; b < beats; b++) begin
      s_udp_payload_axis_tdata = beat_data(f, b);
      s_udp_payload_axis_tkeep = b == beats - 1 ? byte_mask(final_bytes) : 8'hff;
      s_udp_payload_axis_tlast = b == beats - 1;
      s_udp_payload_axis_tvalid = 1'b1;
      do begin
        ok = s_udp_payload_axis_tready;
        // frame still open until its input tlast is taken
        check_busy(1'b1, f);
        @(negedge clk);
      end while (!ok);
    end
    s_udp_payload_axis_tvalid = 1'b0;
    s_udp_payload_axis_tlast = 1'b0;
    check_busy(1'b0, f);
  endtask

  task check_header;
    if (exp_ip.size() == 0) begin
      check_value(1'b0, "an IP header came out with none expected");
    end else begin
      want_ip = exp_ip.pop_front();
      want_len = exp_len.pop_front();
      want_roce = exp_roce.pop_front();
      check_value(got_ip == want_ip, $sformatf("IP fields %h, expected %h", got_ip, want_ip));
      check_value(m_ip_length == want_len && m_is_roce_packet == want_roce,
                  $sformatf("ip_length %0d roce %b, expected %0d %b",
                            m_ip_length, m_is_roce_packet, want_len, want_roce));
    end
  endtask

  task check_beat;
    if (exp_data.size() == 0) begin
      check_value(1'b0, "an output beat came out with none expected");
    end else begin
      want_data = exp_data.pop_front();
      want_keep = exp_keep.pop_front();
      want_last = exp_last.pop_front();
      want_user = exp_user.pop_front();
      check_value(m_ip_payload_axis_tdata == want_data,
                  $sformatf("frame %0d beat %0d tdata %h, expected %h", frames_done,
                            beats_seen, m_ip_payload_axis_tdata, want_data));
      check_value({m_ip_payload_axis_tkeep, m_ip_payload_axis_tlast, m_ip_payload_axis_tuser}
                  == {want_keep, want_last, want_user},
                  $sformatf("frame %0d beat %0d keep/last/user %h %b %b, expected %h %b %b",
                            frames_done, beats_seen, m_ip_payload_axis_tkeep,
                            m_ip_payload_axis_tlast, m_ip_payload_axis_tuser,
                            want_keep, want_last, want_user));
    end
    beats_seen++;
    if (m_ip_payload_axis_tlast) begin
      want_short = exp_short.size() > 0 ? exp_short.pop_front() : 1'b0;
      check_value(err_seen - err_base == (want_short ? 1 : 0),
                  $sformatf("frame %0d error pulses %0d, expected %0d", frames_done,
                            err_seen - err_base, want_short ? 1 : 0));
      $display("frame %0d done: %0d output beats, %0d error pulses, %0d failures so far",
               frames_done, beats_seen, err_seen - err_base, fails);
      err_base = err_seen;
      beats_seen = 0;
      frames_done++;
    end
  endtask

  // random ready on both outputs, then sample what the next edge transfers
  always @(negedge clk) begin
    bp_draw = $random(seed);
    m_ip_payload_axis_tready = !bp_on || bp_draw[1:0] != 2'b00;
    m_ip_hdr_ready = !bp_on || bp_draw[3:2] != 2'b00;
    if (!rst) begin
      if (error_payload_early_termination) begin
        err_seen++;
      end
      if (m_ip_hdr_valid && m_ip_hdr_ready) begin
        check_header();
      end
      if (m_ip_payload_axis_tvalid && m_ip_payload_axis_tready) begin
        check_beat();
      end
    end
  end

  initial begin
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int f = 0; f < n_rows; f++) begin
      send_frame(f);
    end
    while (frames_done < n_rows || exp_ip.size() != 0) begin
      @(negedge clk);
    end
    $display("frames %0d, checks %0d, failures %0d", frames_done, checks + busy_checks,
             fails + busy_fails);
    if (fails == 0 && busy_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    int limit;
    limit = 200;
    for (int f = 0; f < n_rows; f++) begin
      limit += 20 * int'(stim_table[f][15:8]);
    end
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== rtl/axis_out_reg.sv ====
// stream output register with skid entry

`timescale 1ns/1ps

module axis_out_reg (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [udp_tx_pkg::data_w-1:0] out_data,
  input  logic [udp_tx_pkg::keep_w-1:0] out_keep,
  input  logic                          out_valid,
  input  logic                          out_last,
  input  logic                          out_user,
  output logic                          out_ready,
  output logic                          out_ready_early,
  output logic [udp_tx_pkg::data_w-1:0] m_ip_payload_axis_tdata,
  output logic [udp_tx_pkg::keep_w-1:0] m_ip_payload_axis_tkeep,
  output logic                          m_ip_payload_axis_tvalid,
  input  logic                          m_ip_payload_axis_tready,
  output logic                          m_ip_payload_axis_tlast,
  output logic                          m_ip_payload_axis_tuser
);
  import udp_tx_pkg::*;

  logic m_valid_next;
  logic [data_w-1:0] temp_data;
  logic [keep_w-1:0] temp_keep;
  logic temp_valid, temp_valid_next;
  logic temp_last;
  logic temp_user;
  logic store_in_to_out;
  logic store_in_to_temp;
  logic store_temp_to_out;

  // accept next cycle if the sink takes data or both entries are empty
  assign out_ready_early = m_ip_payload_axis_tready || (!temp_valid && !m_ip_payload_axis_tvalid);

  always_comb begin
    m_valid_next = m_ip_payload_axis_tvalid;
    temp_valid_next = temp_valid;
    store_in_to_out = 1'b0;
    store_in_to_temp = 1'b0;
    store_temp_to_out = 1'b0;
    if (out_ready) begin
      if (m_ip_payload_axis_tready || !m_ip_payload_axis_tvalid) begin
        m_valid_next = out_valid;
        store_in_to_out = 1'b1;
      end else begin
        // sink stalled, park the word in the second entry
        temp_valid_next = out_valid;
        store_in_to_temp = 1'b1;
      end
    end else if (m_ip_payload_axis_tready) begin
      m_valid_next = temp_valid;
      temp_valid_next = 1'b0;
      store_temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_ip_payload_axis_tvalid <= 1'b0;
      temp_valid <= 1'b0;
      out_ready <= 1'b0;
    end else begin
      m_ip_payload_axis_tvalid <= m_valid_next;
      temp_valid <= temp_valid_next;
      out_ready <= out_ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      m_ip_payload_axis_tdata <= out_data;
      m_ip_payload_axis_tkeep <= out_keep;
      m_ip_payload_axis_tlast <= out_last;
      m_ip_payload_axis_tuser <= out_user;
    end else if (store_temp_to_out) begin
      m_ip_payload_axis_tdata <= temp_data;
      m_ip_payload_axis_tkeep <= temp_keep;
      m_ip_payload_axis_tlast <= temp_last;
      m_ip_payload_axis_tuser <= temp_user;
    end
    if (store_in_to_temp) begin
      temp_data <= out_data;
      temp_keep <= out_keep;
      temp_last <= out_last;
      temp_user <= out_user;
    end
  end

endmodule

// ==== rtl/udp_hdr_latch.sv ====
// UDP header latch

`timescale 1ns/1ps

module udp_hdr_latch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  s_udp_hdr_valid,
  output logic                  s_udp_hdr_ready,
  input  logic [3:0]            s_ip_version,
  input  logic [3:0]            s_ip_ihl,
  input  logic [5:0]            s_ip_dscp,
  input  logic [1:0]            s_ip_ecn,
  input  logic [15:0]           s_ip_identification,
  input  logic [2:0]            s_ip_flags,
  input  logic [12:0]           s_ip_fragment_offset,
  input  logic [7:0]            s_ip_ttl,
  input  logic [7:0]            s_ip_protocol,
  input  logic [15:0]           s_ip_header_checksum,
  input  logic [31:0]           s_ip_source_ip,
  input  logic [31:0]           s_ip_dest_ip,
  input  logic [15:0]           s_udp_source_port,
  input  logic [15:0]           s_udp_dest_port,
  input  logic [15:0]           s_udp_length,
  input  logic [15:0]           s_udp_checksum,
  output logic                  m_ip_hdr_valid,
  input  logic                  m_ip_hdr_ready,
  output logic [3:0]            m_ip_version,
  output logic [3:0]            m_ip_ihl,
  output logic [5:0]            m_ip_dscp,
  output logic [1:0]            m_ip_ecn,
  output logic [15:0]           m_ip_length,
  output logic [15:0]           m_ip_identification,
  output logic [2:0]            m_ip_flags,
  output logic [12:0]           m_ip_fragment_offset,
  output logic [7:0]            m_ip_ttl,
  output logic [7:0]            m_ip_protocol,
  output logic [15:0]           m_ip_header_checksum,
  output logic [31:0]           m_ip_source_ip,
  output logic [31:0]           m_ip_dest_ip,
  output logic                  m_is_roce_packet,
  input  logic                  framer_idle,
  output logic                  hdr_accept,
  output udp_tx_pkg::udp_word_t hdr_word,
  output logic [15:0]           udp_length
);
  import udp_tx_pkg::*;

  logic hdr_valid_next;
  logic is_roce;

  // network byte order for one 16-bit field
  function automatic logic [15:0] swap16(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  assign hdr_accept = s_udp_hdr_valid && s_udp_hdr_ready;
  assign udp_length = s_udp_length;
  assign is_roce = s_udp_dest_port == roce_udp_port;

  // IP header held until the IP side takes it
  assign hdr_valid_next = hdr_accept || (m_ip_hdr_valid && !m_ip_hdr_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      s_udp_hdr_ready <= 1'b0;
      m_ip_hdr_valid <= 1'b0;
    end else begin
      // next header only once the framer is free and nothing waits downstream
      s_udp_hdr_ready <= framer_idle && !hdr_valid_next;
      m_ip_hdr_valid <= hdr_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_accept) begin
      m_ip_version <= s_ip_version;
      m_ip_ihl <= s_ip_ihl;
      m_ip_dscp <= s_ip_dscp;
      m_ip_ecn <= s_ip_ecn;
      m_ip_length <= s_udp_length + ip_hdr_bytes;
      m_ip_identification <= s_ip_identification;
      m_ip_flags <= s_ip_flags;
      m_ip_fragment_offset <= s_ip_fragment_offset;
      m_ip_ttl <= s_ip_ttl;
      m_ip_protocol <= s_ip_protocol;
      m_ip_header_checksum <= s_ip_header_checksum;
      m_ip_source_ip <= s_ip_source_ip;
      m_ip_dest_ip <= s_ip_dest_ip;
      m_is_roce_packet <= is_roce;
      hdr_word.hdr.source_port <= swap16(s_udp_source_port);
      hdr_word.hdr.dest_port <= swap16(s_udp_dest_port);
      // ICRC counted in the UDP length only, IP length unchanged
      hdr_word.hdr.length <= swap16(is_roce ? s_udp_length + icrc_bytes : s_udp_length);
      hdr_word.hdr.checksum <= swap16(s_udp_checksum);
    end
  end

endmodule

// ==== rtl/udp_ip_tx.sv ====
// UDP to IP transmit top level

`timescale 1ns/1ps

module udp_ip_tx (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          s_udp_hdr_valid,
  output logic                          s_udp_hdr_ready,
  input  logic [3:0]                    s_ip_version,
  input  logic [3:0]                    s_ip_ihl,
  input  logic [5:0]                    s_ip_dscp,
  input  logic [1:0]                    s_ip_ecn,
  input  logic [15:0]                   s_ip_identification,
  input  logic [2:0]                    s_ip_flags,
  input  logic [12:0]                   s_ip_fragment_offset,
  input  logic [7:0]                    s_ip_ttl,
  input  logic [7:0]                    s_ip_protocol,
  input  logic [15:0]                   s_ip_header_checksum,
  input  logic [31:0]                   s_ip_source_ip,
  input  logic [31:0]                   s_ip_dest_ip,
  input  logic [15:0]                   s_udp_source_port,
  input  logic [15:0]                   s_udp_dest_port,
  input  logic [15:0]                   s_udp_length,
  input  logic [15:0]                   s_udp_checksum,
  input  logic [udp_tx_pkg::data_w-1:0] s_udp_payload_axis_tdata,
  input  logic [udp_tx_pkg::keep_w-1:0] s_udp_payload_axis_tkeep,
  input  logic                          s_udp_payload_axis_tvalid,
  output logic                          s_udp_payload_axis_tready,
  input  logic                          s_udp_payload_axis_tlast,
  input  logic                          s_udp_payload_axis_tuser,
  output logic                          m_ip_hdr_valid,
  input  logic                          m_ip_hdr_ready,
  output logic [3:0]                    m_ip_version,
  output logic [3:0]                    m_ip_ihl,
  output logic [5:0]                    m_ip_dscp,
  output logic [1:0]                    m_ip_ecn,
  output logic [15:0]                   m_ip_length,
  output logic [15:0]                   m_ip_identification,
  output logic [2:0]                    m_ip_flags,
  output logic [12:0]                   m_ip_fragment_offset,
  output logic [7:0]                    m_ip_ttl,
  output logic [7:0]                    m_ip_protocol,
  output logic [15:0]                   m_ip_header_checksum,
  output logic [31:0]                   m_ip_source_ip,
  output logic [31:0]                   m_ip_dest_ip,
  output logic                          m_is_roce_packet,
  output logic [udp_tx_pkg::data_w-1:0] m_ip_payload_axis_tdata,
  output logic [udp_tx_pkg::keep_w-1:0] m_ip_payload_axis_tkeep,
  output logic                          m_ip_payload_axis_tvalid,
  input  logic                          m_ip_payload_axis_tready,
  output logic                          m_ip_payload_axis_tlast,
  output logic                          m_ip_payload_axis_tuser,
  output logic                          busy,
  output logic                          error_payload_early_termination
);
  import udp_tx_pkg::*;

  // latch to framer and tracker
  logic hdr_accept;
  udp_word_t hdr_word;
  logic [15:0] udp_length;
  logic framer_idle;

  // tracker and framer
  logic beat;
  logic last_beat;
  logic [keep_w-1:0] trim_keep;
  logic short_frame;

  // framer to output register
  logic [data_w-1:0] out_data;
  logic [keep_w-1:0] out_keep;
  logic out_valid;
  logic out_last;
  logic out_user;
  logic out_ready;
  logic out_ready_early;

  udp_hdr_latch u_hdr_latch (.*);

  udp_len_tracker u_len_tracker (.*);

  udp_tx_framer u_framer (.*);

  axis_out_reg u_out_reg (.*);

endmodule

// ==== rtl/udp_len_tracker.sv ====
// UDP payload length tracker

`timescale 1ns/1ps

module udp_len_tracker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          hdr_accept,
  input  logic [15:0]                   udp_length,
  input  logic                          beat,
  input  logic [udp_tx_pkg::keep_w-1:0] s_udp_payload_axis_tkeep,
  input  logic                          s_udp_payload_axis_tlast,
  output logic                          last_beat,
  output logic [udp_tx_pkg::keep_w-1:0] trim_keep,
  output logic                          short_frame
);
  import udp_tx_pkg::*;

  // payload bytes still owed to the frame
  logic [15:0] remaining;

  // valid bytes in a keep word, contiguous from bit 0
  function automatic logic [3:0] keep_count(input logic [keep_w-1:0] k);
    logic [3:0] n;
    n = '0;
    for (int i = 0; i < keep_w; i++) begin
      n = n + 4'(k[i]);
    end
    return n;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
    end else if (hdr_accept) begin
      remaining <= udp_length - udp_hdr_bytes;
    end else if (beat) begin
      remaining <= remaining - 16'(keep_w);
    end
  end

  assign last_beat = remaining <= 16'(keep_w);

  // one low bit per remaining byte, all ones while a full word is owed
  always_comb begin
    for (int i = 0; i < keep_w; i++) begin
      trim_keep[i] = remaining > 16'(i);
    end
  end

  // tlast with fewer bytes than owed, covers tlast before the last beat too
  assign short_frame = s_udp_payload_axis_tlast &&
                       (16'(keep_count(s_udp_payload_axis_tkeep)) < remaining);

endmodule

// ==== rtl/udp_tx_framer.sv ====
// UDP transmit framer FSM

`timescale 1ns/1ps

module udp_tx_framer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          hdr_accept,
  input  udp_tx_pkg::udp_word_t         hdr_word,
  input  logic [udp_tx_pkg::data_w-1:0] s_udp_payload_axis_tdata,
  input  logic [udp_tx_pkg::keep_w-1:0] s_udp_payload_axis_tkeep,
  input  logic                          s_udp_payload_axis_tvalid,
  output logic                          s_udp_payload_axis_tready,
  input  logic                          s_udp_payload_axis_tlast,
  input  logic                          s_udp_payload_axis_tuser,
  input  logic                          last_beat,
  input  logic [udp_tx_pkg::keep_w-1:0] trim_keep,
  input  logic                          short_frame,
  input  logic                          out_ready,
  input  logic                          out_ready_early,
  output logic                          framer_idle,
  output logic                          beat,
  output logic [udp_tx_pkg::data_w-1:0] out_data,
  output logic [udp_tx_pkg::keep_w-1:0] out_keep,
  output logic                          out_valid,
  output logic                          out_last,
  output logic                          out_user,
  output logic                          busy,
  output logic                          error_payload_early_termination
);
  import udp_tx_pkg::*;

  framer_state_t state, state_next;
  logic tready_next;
  logic err_next;
  logic store_last;
  logic [data_w-1:0] last_data;
  logic [keep_w-1:0] last_keep;

  assign framer_idle = state == st_idle;
  assign beat = s_udp_payload_axis_tvalid && s_udp_payload_axis_tready;

  always_comb begin
    state_next = state;
    tready_next = 1'b0;
    err_next = 1'b0;
    store_last = 1'b0;
    out_data = s_udp_payload_axis_tdata;
    out_keep = s_udp_payload_axis_tkeep & trim_keep;
    out_valid = 1'b0;
    out_last = s_udp_payload_axis_tlast;
    out_user = s_udp_payload_axis_tuser;
    case (state)
      st_idle: begin
        if (hdr_accept) begin
          state_next = st_write_header;
        end
      end
      st_write_header: begin
        // UDP header word leaves from the latched copy
        out_data = hdr_word.raw;
        out_keep = '1;
        out_valid = 1'b1;
        out_last = 1'b0;
        out_user = 1'b0;
        if (out_ready) begin
          tready_next = out_ready_early;
          state_next = st_write_payload;
        end
      end
      st_write_payload: begin
        tready_next = out_ready_early;
        if (beat) begin
          if (s_udp_payload_axis_tlast) begin
            // input ends here, short if fewer bytes than owed
            out_valid = 1'b1;
            out_user = s_udp_payload_axis_tuser || short_frame;
            err_next = short_frame;
            tready_next = 1'b0;
            state_next = st_idle;
          end else if (last_beat) begin
            // length reached before input tlast, hold the trimmed word
            store_last = 1'b1;
            state_next = st_write_last;
          end else begin
            out_valid = 1'b1;
          end
        end
      end
      st_write_last: begin
        // drop extra input beats until tlast
        tready_next = out_ready_early;
        out_data = last_data;
        out_keep = last_keep;
        out_last = 1'b1;
        if (beat && s_udp_payload_axis_tlast) begin
          out_valid = 1'b1;
          tready_next = 1'b0;
          state_next = st_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      s_udp_payload_axis_tready <= 1'b0;
      busy <= 1'b0;
      error_payload_early_termination <= 1'b0;
    end else begin
      state <= state_next;
      s_udp_payload_axis_tready <= tready_next;
      busy <= state_next != st_idle;
      error_payload_early_termination <= err_next;
    end
  end

  always_ff @(posedge clk) begin
    if (store_last) begin
      last_data <= s_udp_payload_axis_tdata;
      last_keep <= s_udp_payload_axis_tkeep & trim_keep;
    end
  end

endmodule

// ==== rtl/udp_tx_pkg.sv ====
// UDP transmit framer definitions

package udp_tx_pkg;

  // datapath widths
  localparam int unsigned data_w = 64;
  localparam int unsigned keep_w = 8;

  // RoCEv2 destination port
  localparam logic [15:0] roce_udp_port = 16'd4791;

  // RoCE frames carry a trailing ICRC counted in the UDP length
  localparam logic [15:0] icrc_bytes = 16'd4;

  // header sizes in bytes
  localparam logic [15:0] ip_hdr_bytes = 16'd20;
  localparam logic [15:0] udp_hdr_bytes = 16'd8;

  // UDP header lanes, each 16-bit value already in wire byte order
  typedef struct packed {
    logic [15:0] checksum;
    logic [15:0] length;
    logic [15:0] dest_port;
    logic [15:0] source_port;
  } udp_hdr_lanes_t;

  // one stream word, either raw payload or the UDP header
  typedef union packed {
    logic [data_w-1:0] raw;
    udp_hdr_lanes_t    hdr;
  } udp_word_t;

  typedef enum logic [1:0] {
    st_idle,
    st_write_header,
    st_write_payload,
    st_write_last
  } framer_state_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module udp_ip_tx_tb -f src.f -o udp_ip_tx_sim \
  && ./obj_dir/udp_ip_tx_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

// ==== src.f ====
rtl/udp_tx_pkg.sv
rtl/udp_hdr_latch.sv
rtl/udp_len_tracker.sv
rtl/udp_tx_framer.sv
rtl/axis_out_reg.sv
rtl/udp_ip_tx.sv
dv/udp_ip_tx_assert.sv
dv/udp_ip_tx_tb.sv
